//--- aluDecoder.sv
// ==========================================================================
// ALU decoder: refines the FSM's operation class with funct3 and bit 30.
// ==========================================================================
`timescale 1ns/10ps

module aluDecoder (
  input  rvControlPkg::aluOpClass_t aluOp,
  input  logic [2:0]                funct3,
  input  logic                      funct7b5,
  input  logic                      opIsReg,  // opcode bit 5, set for R-type
  output rvControlPkg::aluCtrl_t    aluCtrl
);

  logic isSub;

  assign isSub = funct7b5 & opIsReg; // immediates never subtract

  always_comb begin
    case (aluOp)
      rvControlPkg::OPC_ADD: aluCtrl = rvControlPkg::ALU_ADD;
      rvControlPkg::OPC_SUB: aluCtrl = rvControlPkg::ALU_SUB;
      default: begin
        // RTYPE and ITYPE share the funct3 map
        case (funct3)
          3'b000:  aluCtrl = isSub ? rvControlPkg::ALU_SUB : rvControlPkg::ALU_ADD;
          3'b001:  aluCtrl = rvControlPkg::ALU_SLL;
          3'b010:  aluCtrl = rvControlPkg::ALU_SLT;
          3'b011:  aluCtrl = rvControlPkg::ALU_SLTU;
          3'b100:  aluCtrl = rvControlPkg::ALU_XOR;
          3'b101:  aluCtrl = funct7b5 ? rvControlPkg::ALU_SRA : rvControlPkg::ALU_SRL;
          3'b110:  aluCtrl = rvControlPkg::ALU_OR;
          default: aluCtrl = rvControlPkg::ALU_AND;
        endcase
      end
    endcase
  end

endmodule

//--- controlFsm.sv
// ==========================================================================
// Moore FSM stepping each RV32I instruction through its states and
// driving the control word for the multi-cycle datapath.
// ==========================================================================
`timescale 1ns/10ps

module controlFsm (
  input  logic                      clk,
  input  logic                      reset,
  input  rvControlPkg::opcode_t     opcode,
  input  logic                      zeroFlag,
  output rvControlPkg::ctrlSignals_t ctrl,
  output rvControlPkg::ctrlState_t  state
);

  rvControlPkg::ctrlState_t curState;
  rvControlPkg::ctrlState_t nextState;

  always_ff @(posedge clk) begin
    if (reset) curState <= rvControlPkg::FETCH;
    else       curState <= nextState;
  end

  assign state = curState;

  // next state
  always_comb begin
    nextState = rvControlPkg::FETCH;
    case (curState)
      rvControlPkg::FETCH: nextState = rvControlPkg::DECODE;
      rvControlPkg::DECODE: begin
        case (opcode)
          rvControlPkg::R_TYPE:  nextState = rvControlPkg::EXECUTE_R;
          rvControlPkg::I_LOGIC: nextState = rvControlPkg::EXECUTE_I;
          rvControlPkg::I_LOAD:  nextState = rvControlPkg::MEM_ADR;
          rvControlPkg::S_TYPE:  nextState = rvControlPkg::MEM_ADR;
          rvControlPkg::B_TYPE:  nextState = rvControlPkg::BRANCH_EQ;
          rvControlPkg::J_TYPE:  nextState = rvControlPkg::UNCOND_JUMP;
          rvControlPkg::U_LUI:   nextState = rvControlPkg::LUI;
          rvControlPkg::U_AUIPC: nextState = rvControlPkg::AUIPC;
          rvControlPkg::I_JALR:  nextState = rvControlPkg::JALR_CALC;
          default:               nextState = rvControlPkg::DECODE; // wait for a legal opcode
        endcase
      end
      rvControlPkg::MEM_ADR: begin
        if (opcode == rvControlPkg::I_LOAD)      nextState = rvControlPkg::MEM_READ;
        else if (opcode == rvControlPkg::S_TYPE) nextState = rvControlPkg::MEM_WRITE;
        else                                     nextState = rvControlPkg::FETCH;
      end
      rvControlPkg::MEM_READ:    nextState = rvControlPkg::MEM_WB;
      rvControlPkg::JALR_CALC:   nextState = rvControlPkg::JALR_LINK;
      rvControlPkg::JALR_LINK:   nextState = rvControlPkg::ALU_WB;
      rvControlPkg::EXECUTE_R,
      rvControlPkg::EXECUTE_I,
      rvControlPkg::UNCOND_JUMP,
      rvControlPkg::LUI,
      rvControlPkg::AUIPC:       nextState = rvControlPkg::ALU_WB;
      // branch retires through one idle MEM_ADR cycle, 4 cycles like the others
      rvControlPkg::BRANCH_EQ:   nextState = rvControlPkg::MEM_ADR;
      default:                   nextState = rvControlPkg::FETCH; // MEM_WRITE, MEM_WB, ALU_WB
    endcase
  end

  // Moore outputs, only BRANCH_EQ also looks at zeroFlag
  always_comb begin
    ctrl.adrSrc    = rvControlPkg::ADR_PC;
    ctrl.irWrite   = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.pcUpdate  = 1'b0;
    ctrl.pcSrc     = rvControlPkg::PC_INCREMENT;
    ctrl.branch    = 1'b0;
    ctrl.aluSrcA   = rvControlPkg::SRCA_OLD_PC;
    ctrl.aluSrcB   = rvControlPkg::SRCB_FOUR;
    ctrl.aluOp     = rvControlPkg::OPC_ADD;
    ctrl.resultSrc = rvControlPkg::RES_ALU_OUT;
    ctrl.storeEn   = 1'b0;
    case (curState)
      rvControlPkg::FETCH: begin
        ctrl.irWrite  = 1'b1;
        ctrl.pcUpdate = 1'b1;
      end
      rvControlPkg::DECODE: begin
        ctrl.aluSrcB = rvControlPkg::SRCB_IMM_EXT; // precompute branch / jump target
      end
      rvControlPkg::EXECUTE_R: begin
        ctrl.aluSrcA = rvControlPkg::SRCA_RD1;
        ctrl.aluSrcB = rvControlPkg::SRCB_RD2;
        ctrl.aluOp   = rvControlPkg::OPC_RTYPE;
      end
      rvControlPkg::EXECUTE_I: begin
        ctrl.aluSrcA = rvControlPkg::SRCA_RD1;
        ctrl.aluSrcB = rvControlPkg::SRCB_IMM_EXT;
        ctrl.aluOp   = rvControlPkg::OPC_ITYPE;
      end
      rvControlPkg::UNCOND_JUMP: begin
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = rvControlPkg::PC_JUMP; // link value pc+4 on the ALU
      end
      rvControlPkg::MEM_ADR,
      rvControlPkg::JALR_CALC: begin
        ctrl.aluSrcA = rvControlPkg::SRCA_RD1; // rs1 + imm
        ctrl.aluSrcB = rvControlPkg::SRCB_IMM_EXT;
      end
      rvControlPkg::MEM_READ: ctrl.adrSrc = rvControlPkg::ADR_RESULT;
      rvControlPkg::MEM_WRITE: begin
        ctrl.adrSrc  = rvControlPkg::ADR_RESULT;
        ctrl.storeEn = 1'b1;
      end
      rvControlPkg::MEM_WB: begin
        ctrl.resultSrc = rvControlPkg::RES_DATA;
        ctrl.regWrite  = 1'b1;
      end
      rvControlPkg::ALU_WB: ctrl.regWrite = 1'b1;
      rvControlPkg::BRANCH_EQ: begin
        ctrl.aluSrcA  = rvControlPkg::SRCA_RD1;
        ctrl.aluSrcB  = rvControlPkg::SRCB_RD2;
        ctrl.aluOp    = rvControlPkg::OPC_SUB;
        ctrl.branch   = 1'b1;
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = zeroFlag ? rvControlPkg::PC_JUMP : rvControlPkg::PC_INCREMENT;
      end
      rvControlPkg::LUI: begin
        ctrl.aluSrcA = rvControlPkg::SRCA_ZERO;
        ctrl.aluSrcB = rvControlPkg::SRCB_IMM_EXT;
      end
      rvControlPkg::AUIPC: ctrl.aluSrcB = rvControlPkg::SRCB_IMM_EXT;
      rvControlPkg::JALR_LINK: begin
        ctrl.pcUpdate = 1'b1;
        ctrl.pcSrc    = rvControlPkg::PC_ALU_RESULT; // target held from JALR_CALC
      end
      default: ctrl.irWrite = 1'b0;
    endcase
  end

endmodule

//--- controlUnit.sv
// ==========================================================================
// RV32I control unit top: slices the instruction and ties the FSM, ALU
// decoder and store mask generator together.
// ==========================================================================
`timescale 1ns/10ps

module controlUnit (
  input  logic                                  clk,
  input  logic                                  reset,
  input  logic [31:0]                           instr,
  input  logic                                  zeroFlag,
  input  logic [1:0]                            adrLow,   // low bits of computed address
  output rvControlPkg::ctrlSignals_t            ctrl,
  output rvControlPkg::aluCtrl_t                aluCtrl,
  output logic [rvControlPkg::STORE_MASK_WIDTH-1:0] memWrite,
  output rvControlPkg::ctrlState_t              state
);

  rvControlPkg::opcode_t opcode;
  logic [2:0]            funct3;
  logic                  funct7b5;

  assign opcode   = rvControlPkg::opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7b5 = instr[30];

  controlFsm controlFsm_inst (
    .clk      (clk),
    .reset    (reset),
    .opcode   (opcode),
    .zeroFlag (zeroFlag),
    .ctrl     (ctrl),
    .state    (state)
  );

  aluDecoder aluDecoder_inst (
    .aluOp    (ctrl.aluOp),
    .funct3   (funct3),
    .funct7b5 (funct7b5),
    .opIsReg  (instr[5]),
    .aluCtrl  (aluCtrl)
  );

  storeMaskGen storeMaskGen_inst (
    .storeEn  (ctrl.storeEn),
    .funct3   (funct3),
    .adrLow   (adrLow),
    .memWrite (memWrite)
  );

endmodule

//--- controlUnitCases.txt
# instr zeroFlag adrLow cycles aluCtrl memWrite (all hex except cycles, decimal)
# cycles 0 marks an illegal opcode that must hold the FSM in DECODE
003100B3 0 0 4 0 0
403100B3 0 0 4 1 0
003110B3 0 0 4 2 0
003120B3 0 0 4 3 0
003130B3 0 0 4 4 0
003140B3 0 0 4 5 0
003150B3 0 0 4 6 0
403150B3 0 0 4 7 0
003160B3 0 0 4 8 0
003170B3 0 0 4 9 0
00510093 0 0 4 0 0
C0010093 0 0 4 0 0
00311093 0 0 4 2 0
00315093 0 0 4 6 0
40315093 0 0 4 7 0
00517093 0 0 4 9 0
00012083 0 2 5 0 0
00010083 0 3 5 0 0
00310023 0 0 4 0 1
00310023 0 1 4 0 2
00310023 0 2 4 0 4
00310023 0 3 4 0 8
00311023 0 0 4 0 3
00311023 0 1 4 0 3
00311023 0 2 4 0 C
00311023 0 3 4 0 C
00312023 0 0 4 0 F
00312023 0 1 4 0 F
00312023 0 2 4 0 F
00312023 0 3 4 0 F
00310463 1 0 4 1 0
00310463 0 0 4 1 0
000000EF 0 0 4 0 0
000100E7 0 0 5 0 0
123450B7 0 0 4 0 0
00001097 0 0 4 0 0
0000007F 0 0 0 0 0
003100B3 0 0 4 0 0
00000000 0 0 0 0 0
00312023 0 1 4 0 F

//--- controlUnitTb.sv
// ==========================================================================
// Testbench for the RV32I control unit: runs each instruction listed in
// controlUnitCases.txt through the FSM and checks counts, ALU code and mask.
// ==========================================================================
`timescale 1ns/10ps

module controlUnitTb;

  localparam int WAIT_LIMIT  = 20; // cycles allowed for any single wait
  localparam int HOLD_CYCLES = 8;  // DECODE cycles checked for an illegal opcode

  logic                                      clk;
  logic                                      reset;
  logic [31:0]                               instr;
  logic                                      zeroFlag;
  logic [1:0]                                adrLow;
  rvControlPkg::ctrlSignals_t                ctrl;
  rvControlPkg::aluCtrl_t                    aluCtrl;
  logic [rvControlPkg::STORE_MASK_WIDTH-1:0] memWrite;
  rvControlPkg::ctrlState_t                  state;

  bit stuckInDecode; // last case left an illegal opcode waiting in DECODE
  int caseCount;

  controlUnit controlUnit_inst (
    .clk      (clk),
    .reset    (reset),
    .instr    (instr),
    .zeroFlag (zeroFlag),
    .adrLow   (adrLow),
    .ctrl     (ctrl),
    .aluCtrl  (aluCtrl),
    .memWrite (memWrite),
    .state    (state)
  );

  always #20 clk = ~clk;

  task automatic reportMismatch(input string msg);
    $display("Error: time %0t: %s", $time, msg);
    $display("Testbench failed");
    $fatal(1, "value mismatch");
  endtask

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "run aborted");
  endtask

  task automatic checkState(input rvControlPkg::ctrlState_t got,
                            input rvControlPkg::ctrlState_t exp, input string tag);
    if (got !== exp) reportMismatch($sformatf("%s: state %s, expected %s", tag,
                                              got.name(), exp.name()));
  endtask

  task automatic checkCtrl(input rvControlPkg::ctrlSignals_t got,
                           input rvControlPkg::ctrlSignals_t exp, input string tag);
    if (got !== exp) reportMismatch($sformatf("%s: ctrl %h, expected %h", tag, got, exp));
  endtask

  task automatic checkAluCtrl(input rvControlPkg::aluCtrl_t got,
                              input rvControlPkg::aluCtrl_t exp, input string tag);
    if (got !== exp) reportMismatch($sformatf("%s: aluCtrl %s, expected %s", tag,
                                              got.name(), exp.name()));
  endtask

  task automatic checkMask(input logic [3:0] got, input logic [3:0] exp, input string tag);
    if (got !== exp) reportMismatch($sformatf("%s: memWrite %b, expected %b", tag, got, exp));
  endtask

  task automatic checkCount(input int got, input int exp, input string tag);
    if (got != exp) reportMismatch($sformatf("%s: took %0d cycles, expected %0d", tag, got, exp));
  endtask

  // control word expected in FETCH
  function automatic rvControlPkg::ctrlSignals_t fetchCtrl();
    rvControlPkg::ctrlSignals_t c;
    c.adrSrc    = rvControlPkg::ADR_PC;
    c.irWrite   = 1'b1;
    c.regWrite  = 1'b0;
    c.pcUpdate  = 1'b1;
    c.pcSrc     = rvControlPkg::PC_INCREMENT;
    c.branch    = 1'b0;
    c.aluSrcA   = rvControlPkg::SRCA_OLD_PC;
    c.aluSrcB   = rvControlPkg::SRCB_FOUR;
    c.aluOp     = rvControlPkg::OPC_ADD;
    c.resultSrc = rvControlPkg::RES_ALU_OUT;
    c.storeEn   = 1'b0;
    return c;
  endfunction

  // BRANCH_EQ compares rs1 and rs2, takes the jump only on zero
  function automatic rvControlPkg::ctrlSignals_t branchCtrl(input logic zf);
    rvControlPkg::ctrlSignals_t c;
    c.adrSrc    = rvControlPkg::ADR_PC;
    c.irWrite   = 1'b0;
    c.regWrite  = 1'b0;
    c.pcUpdate  = 1'b1;
    c.pcSrc     = zf ? rvControlPkg::PC_JUMP : rvControlPkg::PC_INCREMENT;
    c.branch    = 1'b1;
    c.aluSrcA   = rvControlPkg::SRCA_RD1;
    c.aluSrcB   = rvControlPkg::SRCB_RD2;
    c.aluOp     = rvControlPkg::OPC_SUB;
    c.resultSrc = rvControlPkg::RES_ALU_OUT;
    c.storeEn   = 1'b0;
    return c;
  endfunction

  task automatic waitForFetch();
    int waited;
    waited = 0;
    while (state != rvControlPkg::FETCH) begin
      if (waited == WAIT_LIMIT) abortRun("Timeout: the FSM did not come back to FETCH");
      else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic holdInDecode(input string tag);
    repeat (HOLD_CYCLES) begin
      @(negedge clk);
      checkState(state, rvControlPkg::DECODE, tag);
      checkMask(memWrite, 4'b0000, tag);
    end
    stuckInDecode = 1'b1;
  endtask

  task automatic runCase(input logic [31:0] caseInstr, input logic caseZero,
                         input logic [1:0] caseAdr, input int expCycles,
                         input rvControlPkg::aluCtrl_t expAlu, input logic [3:0] expMask);
    int    cycle;
    bit    done;
    string tag;
    tag = $sformatf("case %0d instr %h", caseCount, caseInstr);
    if (!stuckInDecode) waitForFetch();
    @(posedge clk);
    instr    <= caseInstr;
    zeroFlag <= caseZero;
    adrLow   <= caseAdr;
    if (expCycles == 0) holdInDecode(tag); // illegal opcode
    else begin
      cycle = 0;
      done  = 1'b0;
      while (!done) begin
        @(negedge clk);
        cycle++;
        checkMask(memWrite, (cycle == 3) ? expMask : 4'b0000, tag); // MEM_WRITE is cycle 3
        if (state == rvControlPkg::FETCH) begin
          checkCount(cycle, expCycles, tag);
          done = 1'b1;
        end else if (cycle > WAIT_LIMIT) begin
          abortRun($sformatf("Timeout: %s never finished", tag));
        end else begin
          if (cycle == 1) checkState(state, rvControlPkg::DECODE, tag);
          if (cycle == 2) begin
            checkAluCtrl(aluCtrl, expAlu, tag);
            if (caseInstr[6:0] == rvControlPkg::B_TYPE) checkCtrl(ctrl, branchCtrl(caseZero), tag);
          end
        end
      end
      stuckInDecode = 1'b0;
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    logic [31:0] fInstr;
    logic [31:0] fZero;
    logic [31:0] fAdr;
    int          fCycles;
    logic [31:0] fAlu;
    logic [31:0] fMask;
    clk           = 1'b0;
    reset         = 1'b1;
    instr         = 32'h00000013; // addi x0, x0, 0
    zeroFlag      = 1'b0;
    adrLow        = 2'b00;
    stuckInDecode = 1'b0;
    caseCount     = 0;
    repeat (10) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    checkState(state, rvControlPkg::FETCH, "after reset");
    checkCtrl(ctrl, fetchCtrl(), "after reset");
    checkMask(memWrite, 4'b0000, "after reset");
    fd = $fopen("controlUnitCases.txt", "r");
    if (fd == 0) abortRun("Could not open controlUnitCases.txt");
    else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %d %h %h", fInstr, fZero, fAdr, fCycles, fAlu, fMask);
          if (fields != 6) abortRun($sformatf("Malformed line in the case file: %s", line));
          else begin
            caseCount++;
            runCase(fInstr, fZero[0], fAdr[1:0], fCycles,
                    rvControlPkg::aluCtrl_t'(fAlu[3:0]), fMask[3:0]);
          end
        end
      end
      $fclose(fd);
      if (caseCount == 0) abortRun("The case file holds no test cases");
      else begin
        $display("Testbench passed");
        $finish;
      end
    end
  end

endmodule

//--- controlUnit_assert.sv
// ==========================================================================
// Bound checks on the control FSM: strobes only in their own states, and
// the state register returning to FETCH out of reset.
// ==========================================================================
`timescale 1ns/10ps

module controlUnit_assert (
  input logic                       clk,
  input logic                       reset,
  input rvControlPkg::ctrlSignals_t ctrl,
  input rvControlPkg::ctrlState_t   state
);

  irWriteOnlyInFetch: assert property (@(posedge clk) disable iff (reset)
    ctrl.irWrite |-> state == rvControlPkg::FETCH)
    else $error("irWrite high outside FETCH");

  // register writes happen only in the two write-back states
  regWriteOnlyInWb: assert property (@(posedge clk) disable iff (reset)
    ctrl.regWrite |-> (state == rvControlPkg::ALU_WB || state == rvControlPkg::MEM_WB))
    else $error("regWrite high outside ALU_WB and MEM_WB");

  storeOnlyInMemWrite: assert property (@(posedge clk) disable iff (reset)
    ctrl.storeEn |-> state == rvControlPkg::MEM_WRITE)
    else $error("storeEn high outside MEM_WRITE");

  fetchAfterReset: assert property (@(posedge clk) reset |=> state == rvControlPkg::FETCH)
    else $error("state is not FETCH after reset");

endmodule

bind controlFsm controlUnit_assert controlUnit_assert_inst (
  .clk   (clk),
  .reset (reset),
  .ctrl  (ctrl),
  .state (state)
);

//--- runSim.sh
#!/bin/sh
# Build the control unit testbench with Verilator and run it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f sources.f --top-module controlUnitTb \
  --Mdir obj_dir -o controlUnitSim && ./obj_dir/controlUnitSim || exit 1

//--- rvControlPkg.sv
// ==========================================================================
// Shared types for the RV32I multi-cycle control unit: states, opcodes,
// datapath selects, ALU codes and the packed control word.
// ==========================================================================
package rvControlPkg;

  localparam int STORE_MASK_WIDTH = 4; // byte lanes per 32-bit word

  typedef enum logic [3:0] {
    FETCH,
    DECODE,
    EXECUTE_R,
    EXECUTE_I,
    UNCOND_JUMP,
    MEM_ADR,
    MEM_READ,
    MEM_WRITE,
    MEM_WB,
    ALU_WB,
    BRANCH_EQ,
    LUI,
    AUIPC,
    JALR_CALC,
    JALR_LINK
  } ctrlState_t;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    R_TYPE  = 7'b0110011,
    I_LOGIC = 7'b0010011,
    I_LOAD  = 7'b0000011,
    I_JALR  = 7'b1100111,
    S_TYPE  = 7'b0100011,
    B_TYPE  = 7'b1100011,
    J_TYPE  = 7'b1101111,
    U_LUI   = 7'b0110111,
    U_AUIPC = 7'b0010111
  } opcode_t;

  typedef enum logic {ADR_PC, ADR_RESULT} adrSrc_t;

  typedef enum logic [1:0] {PC_INCREMENT, PC_JUMP, PC_ALU_RESULT} pcSrc_t;

  typedef enum logic [1:0] {SRCA_OLD_PC, SRCA_RD1, SRCA_ZERO} aluSrcA_t;

  typedef enum logic [1:0] {SRCB_RD2, SRCB_IMM_EXT, SRCB_FOUR} aluSrcB_t;

  typedef enum logic {RES_ALU_OUT, RES_DATA} resultSrc_t;

  // coarse class from the FSM, refined by the ALU decoder
  typedef enum logic [1:0] {OPC_ADD, OPC_SUB, OPC_RTYPE, OPC_ITYPE} aluOpClass_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } aluCtrl_t;

  typedef struct packed {
    adrSrc_t     adrSrc;
    logic        irWrite;
    logic        regWrite;
    logic        pcUpdate;
    pcSrc_t      pcSrc;
    logic        branch;
    aluSrcA_t    aluSrcA;
    aluSrcB_t    aluSrcB;
    aluOpClass_t aluOp;
    resultSrc_t  resultSrc;
    logic        storeEn;   // only in MEM_WRITE
  } ctrlSignals_t;

endpackage

//--- sources.f
rvControlPkg.sv
controlFsm.sv
aluDecoder.sv
storeMaskGen.sv
controlUnit.sv
controlUnit_assert.sv
controlUnitTb.sv

//--- storeMaskGen.sv
// ==========================================================================
// Byte write enables for SB/SH/SW from store width and address bits 1:0.
// ==========================================================================
`timescale 1ns/10ps

module storeMaskGen (
  input  logic                                  storeEn,
  input  logic [2:0]                            funct3,
  input  logic [1:0]                            adrLow,
  output logic [rvControlPkg::STORE_MASK_WIDTH-1:0] memWrite
);

  logic [rvControlPkg::STORE_MASK_WIDTH-1:0] laneMask;

  always_comb begin
    case (funct3)
      3'b000:  laneMask = 4'b0001 << adrLow;           // byte
      3'b001:  laneMask = 4'b0011 << {adrLow[1], 1'b0}; // halfword, lower or upper pair
      3'b010:  laneMask = 4'b1111;                      // word
      default: laneMask = '0;
    endcase
  end

  assign memWrite = storeEn ? laneMask : '0;

endmodule
